//--- sources.f
source/fpu_pkg.sv
source/fpu_ifs.sv
source/fdiv_fsqrt_rs.sv
source/fdiv_unit.sv
source/fsqrt_unit.sv
source/wb_arbiter.sv
source/fdiv_fsqrt_top.sv
tb/fdiv_fsqrt_tb.sv

//--- tb/fdiv_fsqrt_testdata.txt
# op(0 div, 1 sqrt) tag a b rel0 rel1 expected
# rel is cycles after issue when the operand comes over the CDB, 0 = ready at issue
0 0 3f800000 40400000 0 30 3eaaaaab
1 1 40800000 00000000 20 0 40000000
0 2 40c00000 40400000 5 12 40000000
0 3 3f800000 41200000 0 0 3dcccccd
1 4 40000000 00000000 0 0 3fb504f3
0 5 40000000 40400000 0 0 3f2aaaab
1 6 41100000 00000000 0 0 40400000
0 7 c0e00000 40000000 0 0 c0600000
1 8 3e800000 00000000 0 0 3f000000
0 9 3fc00000 3fa00000 0 0 3f99999a
1 10 40400000 00000000 0 0 3fddb3d7
0 11 3f800000 00000000 0 0 7f800000
0 12 bf800000 00000000 0 0 ff800000
1 13 c0800000 00000000 0 0 7fc00000
0 14 00000000 00000000 0 0 7fc00000
1 15 80000000 00000000 0 0 80000000
0 16 7fc00001 3f800000 0 0 7fc00000
1 17 00000000 00000000 0 0 00000000
0 18 7f000000 3e800000 0 0 7f800000
1 19 7f800001 00000000 0 0 7fc00000
0 20 00800000 40000000 0 0 00000000
1 21 00000001 00000000 0 0 00000000
0 22 00400000 3f800000 0 0 00000000

//--- tb/fdiv_fsqrt_tb.sv
`timescale 1ns/1ps

module fdiv_fsqrt_tb;
	import fpu_pkg::*;

	logic clk = 1'b0;
	logic reset;
	logic issue_valid;
	logic issue_ready;
	fp_op_t issue_op;
	logic [TAG_W-1:0] issue_tag;
	logic opd0_ready;
	logic [TAG_W-1:0] opd0_tag;
	fp_word_t opd0_data;
	logic opd1_ready;
	logic [TAG_W-1:0] opd1_tag;
	fp_word_t opd1_data;
	logic cdb_valid;
	logic [TAG_W-1:0] cdb_tag;
	fp_word_t cdb_data;
	logic result_valid;
	logic result_ready;
	logic [TAG_W-1:0] result_tag;
	fp_word_t result_data;

	int errors = 0;
	int received = 0;
	int cyc = 0;
	int limit = 0;  // Zero until the data file is read
	bit saw_full = 0;
	logic [31:0] rng = 32'd43;

	int n_ops = 0;
	int op_a [32];
	int op_tag [32];
	fp_word_t op_x [32];
	fp_word_t op_y [32];
	int op_rel0 [32];
	int op_rel1 [32];
	fp_word_t exp_res [32];  // Indexed by tag
	bit expecting [32];
	bit returned [32];
	int released_at [32];
	int late_left [32];  // Late operands not yet broadcast

	// Pending CDB broadcasts
	int cdb_when [$];
	logic [TAG_W-1:0] cdb_src [$];
	fp_word_t cdb_val [$];
	int cdb_owner [$];

	fdiv_fsqrt_top dut0 (.*);

	always #5 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			$display("Fail %s got %h expected %h", name, got, want);
			errors++;
		end
	endtask

	// Cycle count and timeout
	always @(negedge clk) begin
		cyc <= cyc + 1;
		if (limit > 0 && cyc > limit) begin
			$display("Timeout: only %0d of %0d results came back", received, n_ops);
			$display("TEST FAILED");
			$finish;
		end
	end

	// Random back-pressure
	always @(posedge clk) begin
		rng = xorshift(rng);
		result_ready <= reset || rng[1:0] != 2'b00;
	end

	// CDB driver sends at most one broadcast per cycle
	always @(posedge clk) begin
		cdb_valid <= 1'b0;
		for (int i = 0; i < cdb_when.size(); i++) begin
			if (cdb_when[i] <= cyc) begin
				cdb_valid <= 1'b1;
				cdb_tag <= cdb_src[i];
				cdb_data <= cdb_val[i];
				released_at[cdb_owner[i]] = cyc;
				late_left[cdb_owner[i]]--;
				cdb_when.delete(i);
				cdb_src.delete(i);
				cdb_val.delete(i);
				cdb_owner.delete(i);
				break;
			end
		end
	end

	// Scoreboard sampled mid-cycle where outputs have settled
	always @(negedge clk) begin
		int t;
		int e0;
		if (!reset && issue_valid && !issue_ready)
			saw_full = 1;
		if (!reset && result_valid && result_ready) begin
			t = result_tag;
			e0 = errors;
			if (!expecting[t]) begin
				$display("Result with tag %0d arrived but no such operation was issued", t);
				errors++;
			end else if (returned[t]) begin
				$display("Tag %0d was returned more than once", t);
				errors++;
			end else begin
				returned[t] = 1;
				check_value($sformatf("result_data[tag %0d]", t), result_data, exp_res[t]);
				if (late_left[t] != 0 || cyc <= released_at[t]) begin
					$display("Tag %0d came back before its operand was broadcast", t);
					errors++;
				end
			end
			received++;
			$display("Operation tag %0d: %s", t, errors == e0 ? "ok" : "bad");
		end
	end

	task automatic issue_one(input int k);
		int t;
		t = op_tag[k];
		@(posedge clk);
		issue_valid <= 1'b1;
		issue_op <= op_a[k] ? FSQRT : FDIV;
		issue_tag <= t[TAG_W-1:0];
		opd0_ready <= op_rel0[k] == 0;
		opd0_tag <= 5'(16 + 2 * t);
		opd0_data <= op_rel0[k] == 0 ? op_x[k] : 32'hdeadbeef;
		opd1_ready <= op_rel1[k] == 0;
		opd1_tag <= 5'(17 + 2 * t);
		opd1_data <= op_rel1[k] == 0 ? op_y[k] : 32'hdeadbeef;
		do
			@(negedge clk);
		while (!issue_ready);
		if (op_rel0[k] > 0) begin
			cdb_when.push_back(cyc + op_rel0[k]);
			cdb_src.push_back(5'(16 + 2 * t));
			cdb_val.push_back(op_x[k]);
			cdb_owner.push_back(t);
			late_left[t]++;
		end
		if (op_rel1[k] > 0) begin
			cdb_when.push_back(cyc + op_rel1[k]);
			cdb_src.push_back(5'(17 + 2 * t));
			cdb_val.push_back(op_y[k]);
			cdb_owner.push_back(t);
			late_left[t]++;
		end
	endtask

	initial begin
		int fd;
		int n;
		int max_rel;
		string line;
		int f_op;
		int f_tag;
		int f_r0;
		int f_r1;
		logic [31:0] f_a;
		logic [31:0] f_b;
		logic [31:0] f_e;
		reset = 1'b1;
		issue_valid = 1'b0;
		issue_op = FDIV;
		issue_tag = '0;
		opd0_ready = 1'b0;
		opd0_tag = '0;
		opd0_data = '0;
		opd1_ready = 1'b0;
		opd1_tag = '0;
		opd1_data = '0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		cdb_data = '0;
		result_ready = 1'b1;
		max_rel = 0;
		for (int i = 0; i < 32; i++) begin
			expecting[i] = 0;
			returned[i] = 0;
			released_at[i] = -1;
			late_left[i] = 0;
		end
		fd = $fopen("tb/fdiv_fsqrt_testdata.txt", "r");
		if (fd == 0) begin
			$display("Could not open the test data file");
			$display("TEST FAILED");
			$finish;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() < 2 || line[0] == "#")
					continue;
				n = $sscanf(line, "%d %d %h %h %d %d %h",
					f_op, f_tag, f_a, f_b, f_r0, f_r1, f_e);
				if (n == 7 && n_ops < 32) begin
					op_a[n_ops] = f_op;
					op_tag[n_ops] = f_tag;
					op_x[n_ops] = f_a;
					op_y[n_ops] = f_b;
					op_rel0[n_ops] = f_r0;
					op_rel1[n_ops] = f_op ? 0 : f_r1;  // Root has no opd1
					exp_res[f_tag] = f_e;
					expecting[f_tag] = 1;
					max_rel = f_r0 > max_rel ? f_r0 : max_rel;
					max_rel = f_r1 > max_rel ? f_r1 : max_rel;
					n_ops++;
				end
			end
			$fclose(fd);
			limit = 16 + n_ops * (DIV_CYCLES + 10) + max_rel;

			repeat (16) @(posedge clk);
			reset <= 1'b0;
			@(negedge clk);
			n = errors;
			check_value("result_valid", result_valid, 0);
			check_value("issue_ready", issue_ready, 1);
			$display("Reset state: %s", errors == n ? "ok" : "bad");

			for (int k = 0; k < n_ops; k++)
				issue_one(k);
			@(posedge clk);
			issue_valid <= 1'b0;

			wait (received >= n_ops);
			@(negedge clk);
			if (!saw_full) begin
				$display("issue_ready never fell while both station entries were full");
				errors++;
			end
			$display("Issue back-pressure: %s", saw_full ? "ok" : "bad");
			$display("Done: %0d operations, %0d results, %0d errors", n_ops, received, errors);
			if (errors == 0)
				$display("TEST PASSED");
			else
				$display("TEST FAILED");
			$finish;
		end
	end
endmodule

//--- source/fdiv_fsqrt_top.sv
`timescale 1ns/1ps

module fdiv_fsqrt_top (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	output logic issue_ready,
	input fpu_pkg::fp_op_t issue_op,
	input logic [fpu_pkg::TAG_W-1:0] issue_tag,
	input logic opd0_ready,
	input logic [fpu_pkg::TAG_W-1:0] opd0_tag,
	input fpu_pkg::fp_word_t opd0_data,
	input logic opd1_ready,
	input logic [fpu_pkg::TAG_W-1:0] opd1_tag,
	input fpu_pkg::fp_word_t opd1_data,
	input logic cdb_valid,
	input logic [fpu_pkg::TAG_W-1:0] cdb_tag,
	input fpu_pkg::fp_word_t cdb_data,
	output logic result_valid,
	input logic result_ready,
	output logic [fpu_pkg::TAG_W-1:0] result_tag,
	output fpu_pkg::fp_word_t result_data
);
	issue_if iss ();
	exec_if div_x ();
	exec_if sqrt_x ();

	assign iss.valid = issue_valid;
	assign iss.op = issue_op;
	assign iss.tag = issue_tag;
	assign iss.opd0_ready = opd0_ready;
	assign iss.opd0_tag = opd0_tag;
	assign iss.opd0_data = opd0_data;
	assign iss.opd1_ready = opd1_ready;
	assign iss.opd1_tag = opd1_tag;
	assign iss.opd1_data = opd1_data;
	assign issue_ready = iss.ready;

	fdiv_fsqrt_rs rs0 (
		.clk(clk),
		.reset(reset),
		.iss(iss),
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.cdb_data(cdb_data),
		.div_x(div_x),
		.sqrt_x(sqrt_x)
	);

	fdiv_unit div0 (.clk(clk), .reset(reset), .x(div_x));
	fsqrt_unit sqrt0 (.clk(clk), .reset(reset), .x(sqrt_x));

	wb_arbiter arb0 (
		.clk(clk),
		.reset(reset),
		.div_x(div_x),
		.sqrt_x(sqrt_x),
		.result_valid(result_valid),
		.result_ready(result_ready),
		.result_tag(result_tag),
		.result_data(result_data)
	);
endmodule

//--- source/wb_arbiter.sv
`timescale 1ns/1ps

module wb_arbiter (
	input logic clk,
	input logic reset,
	exec_if.arbiter div_x,
	exec_if.arbiter sqrt_x,
	output logic result_valid,
	input logic result_ready,
	output logic [fpu_pkg::TAG_W-1:0] result_tag,
	output fpu_pkg::fp_word_t result_data
);
	logic last_sqrt;  // Root unit won the last transfer
	logic lock;
	logic lock_sqrt;
	logic pick_sqrt;
	logic take;

	// A stalled choice stays put until it is taken
	assign pick_sqrt = lock ? lock_sqrt : sqrt_x.done && (!div_x.done || !last_sqrt);

	assign result_valid = div_x.done || sqrt_x.done;
	assign result_tag = pick_sqrt ? sqrt_x.rtag : div_x.rtag;
	assign result_data = pick_sqrt ? sqrt_x.result : div_x.result;
	assign take = result_valid && result_ready;
	assign div_x.ack = take && !pick_sqrt;
	assign sqrt_x.ack = take && pick_sqrt;

	always_ff @(posedge clk) begin
		if (reset) begin
			last_sqrt <= 1'b0;
			lock <= 1'b0;
			lock_sqrt <= 1'b0;
		end else begin
			if (take) begin
				last_sqrt <= pick_sqrt;
			end
			lock <= result_valid && !result_ready;
			lock_sqrt <= pick_sqrt;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		result_valid && !result_ready |=>
			result_valid && $stable(result_tag) && $stable(result_data));
endmodule

//--- source/fsqrt_unit.sv
`timescale 1ns/1ps

module fsqrt_unit (
	input logic clk,
	input logic reset,
	exec_if.unit x
);
	import fpu_pkg::*;

	fu_state_t state;
	logic [4:0] cnt;
	logic spec;
	fp_word_t spec_res;
	logic [7:0] exp_q;
	logic [2*SQRT_CYCLES-1:0] rad;
	logic [SQRT_CYCLES+2:0] rem;
	logic [SQRT_CYCLES-1:0] root;
	fp_word_t res;
	logic [TAG_W-1:0] rtag;

	logic [7:0] ea;
	logic odd;
	logic [8:0] sum_e;
	logic s_spec;
	fp_word_t s_res;
	logic [SQRT_CYCLES+2:0] rem_sh;
	logic [SQRT_CYCLES+1:0] trial;
	logic ge;
	logic [23:0] mant;
	logic rnd;
	logic [24:0] mant_r;

	always_comb begin
		ea = x.a[30:23];
		odd = !ea[0];  // Unbiased exponent is odd
		sum_e = {1'b0, ea} + 9'(EXP_BIAS) - {8'd0, odd};
		s_spec = 1'b1;
		if ((ea == 8'hff && x.a[22:0] != '0) || (x.a[31] && ea != 8'h00)) begin
			s_res = QNAN;
		end else if (ea == 8'h00) begin
			s_res = {x.a[31], 31'd0};  // Signed zero passes through
		end else if (ea == 8'hff) begin
			s_res = x.a;
		end else begin
			s_spec = 1'b0;
			s_res = QNAN;
		end
	end

	// One root digit per cycle from the next radicand pair
	always_comb begin
		rem_sh = {rem[SQRT_CYCLES:0], rad[2*SQRT_CYCLES-1 -: 2]};
		trial = {root, 2'b01};
		ge = rem_sh >= {1'b0, trial};
		mant = root[SQRT_CYCLES-1 -: 24];
		rnd = root[0] & ((rem != '0) | mant[0]);
		mant_r = {1'b0, mant} + {24'd0, rnd};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: state <= x.start ? ITER : IDLE;
				ITER: state <= cnt == SQRT_CYCLES - 1 ? ROUND : ITER;
				ROUND: state <= HOLD;
				HOLD: state <= x.ack ? IDLE : HOLD;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && x.start) begin
			cnt <= '0;
			spec <= s_spec;
			spec_res <= s_res;
			exp_q <= sum_e[8:1];
			rad <= {odd ? {1'b1, x.a[22:0], 1'b0} : {2'b01, x.a[22:0]},
				{SQRT_CYCLES{1'b0}}};
			rem <= '0;
			root <= '0;
			rtag <= x.tag;
		end else if (state == ITER) begin
			cnt <= cnt + 5'd1;
			rad <= {rad[2*SQRT_CYCLES-3:0], 2'b00};
			rem <= ge ? rem_sh - {1'b0, trial} : rem_sh;
			root <= {root[SQRT_CYCLES-2:0], ge};
		end else if (state == ROUND) begin
			res <= spec ? spec_res : {1'b0, exp_q + {7'd0, mant_r[24]}, mant_r[22:0]};
		end
	end

	assign x.busy = state != IDLE;
	assign x.done = state == HOLD;
	assign x.result = res;
	assign x.rtag = rtag;
endmodule

//--- source/fdiv_unit.sv
`timescale 1ns/1ps

module fdiv_unit (
	input logic clk,
	input logic reset,
	exec_if.unit x
);
	import fpu_pkg::*;

	fu_state_t state;
	logic [4:0] cnt;
	logic sign;
	logic spec;
	fp_word_t spec_res;
	logic signed [9:0] exp_q;
	logic [23:0] mb;
	logic [25:0] rem;
	logic [DIV_CYCLES-1:0] quo;
	fp_word_t res;
	logic [TAG_W-1:0] rtag;

	logic [7:0] ea;
	logic [7:0] eb;
	logic a_zero;
	logic b_zero;
	logic a_inf;
	logic b_inf;
	logic a_nan;
	logic b_nan;
	logic s_spec;
	fp_word_t s_res;
	logic ge;
	logic norm;
	logic [23:0] mant;
	logic rnd;
	logic [24:0] mant_r;
	logic signed [9:0] exp_r;
	fp_word_t packed_res;

	always_comb begin
		ea = x.a[30:23];
		eb = x.b[30:23];
		a_zero = ea == 8'h00;  // Subnormals flush here
		b_zero = eb == 8'h00;
		a_inf = ea == 8'hff && x.a[22:0] == '0;
		b_inf = eb == 8'hff && x.b[22:0] == '0;
		a_nan = ea == 8'hff && x.a[22:0] != '0;
		b_nan = eb == 8'hff && x.b[22:0] != '0;
		s_spec = 1'b1;
		if (a_nan || b_nan || (a_zero && b_zero) || (a_inf && b_inf)) begin
			s_res = QNAN;
		end else if (a_inf || b_zero) begin
			s_res = {x.a[31] ^ x.b[31], 8'hff, 23'd0};
		end else if (a_zero || b_inf) begin
			s_res = {x.a[31] ^ x.b[31], 31'd0};
		end else begin
			s_spec = 1'b0;
			s_res = QNAN;
		end
	end

	assign ge = rem >= {2'b00, mb};

	always_comb begin
		norm = quo[DIV_CYCLES-1];  // Quotient already in [1,2)
		mant = norm ? quo[DIV_CYCLES-1 -: 24] : quo[DIV_CYCLES-2 -: 24];
		rnd = (norm ? quo[DIV_CYCLES-25] : quo[DIV_CYCLES-26]) &
			((norm & quo[DIV_CYCLES-26]) | (rem != '0) | mant[0]);
		mant_r = {1'b0, mant} + {24'd0, rnd};
		exp_r = exp_q - {9'd0, ~norm} + {9'd0, mant_r[24]};
		if (spec) begin
			packed_res = spec_res;
		end else if (exp_r >= 10'sd255) begin
			packed_res = {sign, 8'hff, 23'd0};
		end else if (exp_r <= 10'sd0) begin
			packed_res = {sign, 31'd0};
		end else begin
			packed_res = {sign, exp_r[7:0], mant_r[22:0]};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: state <= x.start ? ITER : IDLE;
				ITER: state <= cnt == DIV_CYCLES - 1 ? ROUND : ITER;
				ROUND: state <= HOLD;
				HOLD: state <= x.ack ? IDLE : HOLD;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && x.start) begin
			cnt <= '0;
			sign <= x.a[31] ^ x.b[31];
			spec <= s_spec;
			spec_res <= s_res;
			exp_q <= $signed({2'b00, ea} - {2'b00, eb} + 10'(EXP_BIAS));
			rem <= {3'b001, x.a[22:0]};
			mb <= {1'b1, x.b[22:0]};
			quo <= '0;
			rtag <= x.tag;
		end else if (state == ITER) begin
			cnt <= cnt + 5'd1;
			quo <= {quo[DIV_CYCLES-2:0], ge};
			rem <= ge ? {rem[24:0] - {1'b0, mb}, 1'b0} : {rem[24:0], 1'b0};
		end else if (state == ROUND) begin
			res <= packed_res;
		end
	end

	assign x.busy = state != IDLE;  // Held busy through HOLD
	assign x.done = state == HOLD;
	assign x.result = res;
	assign x.rtag = rtag;
endmodule

//--- source/fdiv_fsqrt_rs.sv
`timescale 1ns/1ps

module fdiv_fsqrt_rs (
	input logic clk,
	input logic reset,
	issue_if.station iss,
	input logic cdb_valid,
	input logic [fpu_pkg::TAG_W-1:0] cdb_tag,
	input fpu_pkg::fp_word_t cdb_data,
	exec_if.station div_x,
	exec_if.station sqrt_x
);
	import fpu_pkg::*;

	typedef struct packed {
		logic valid;
		fp_op_t op;
		logic [TAG_W-1:0] tag;
		logic [1:0] rdy;
		logic [1:0][TAG_W-1:0] stag;
		fp_word_t [1:0] data;
	} rs_entry_t;

	rs_entry_t ent [RS_DEPTH];  // Slot 0 is the oldest
	rs_entry_t upd [RS_DEPTH+1];
	rs_entry_t nxt [RS_DEPTH];
	rs_entry_t new_e;
	logic [RS_DEPTH-1:0] vld;
	logic [$clog2(RS_DEPTH)-1:0] sel;
	logic dispatch;
	logic accept;

	// Capture a matching CDB broadcast into waiting operands
	function automatic rs_entry_t wake(rs_entry_t e);
		rs_entry_t w;
		w = e;
		for (int j = 0; j < 2; j++) begin
			if (!e.rdy[j] && cdb_valid && cdb_tag == e.stag[j]) begin
				w.rdy[j] = 1'b1;
				w.data[j] = cdb_data;
			end
		end
		return w;
	endfunction

	always_comb begin
		rs_entry_t e;
		e.valid = 1'b1;
		e.op = iss.op;
		e.tag = iss.tag;
		e.rdy = {iss.op == FSQRT || iss.opd1_ready, iss.opd0_ready};  // Root ignores opd1
		e.stag = {iss.opd1_tag, iss.opd0_tag};
		e.data = {iss.opd1_data, iss.opd0_data};
		new_e = wake(e);
	end

	always_comb begin
		for (int i = 0; i < RS_DEPTH; i++) begin
			upd[i] = wake(ent[i]);
			vld[i] = ent[i].valid;
		end
		upd[RS_DEPTH] = '0;  // Empty fill for compaction
	end

	// Oldest entry with all operands and an idle unit
	always_comb begin
		dispatch = 1'b0;
		sel = '0;
		for (int i = RS_DEPTH - 1; i >= 0; i--) begin
			if (ent[i].valid && (&ent[i].rdy) &&
					!(ent[i].op == FDIV ? div_x.busy : sqrt_x.busy)) begin
				dispatch = 1'b1;
				sel = i[$clog2(RS_DEPTH)-1:0];
			end
		end
	end

	assign iss.ready = !ent[RS_DEPTH-1].valid || dispatch;
	assign accept = iss.valid && iss.ready;

	assign div_x.start = dispatch && ent[sel].op == FDIV;
	assign sqrt_x.start = dispatch && ent[sel].op == FSQRT;
	assign div_x.a = ent[sel].data[0];
	assign div_x.b = ent[sel].data[1];
	assign div_x.tag = ent[sel].tag;
	assign sqrt_x.a = ent[sel].data[0];
	assign sqrt_x.b = ent[sel].data[1];
	assign sqrt_x.tag = ent[sel].tag;

	always_comb begin
		logic placed;
		placed = 1'b0;
		for (int i = 0; i < RS_DEPTH; i++) begin
			nxt[i] = (dispatch && i >= sel) ? upd[i+1] : upd[i];  // Close the gap
			if (accept && !placed && !nxt[i].valid) begin
				nxt[i] = new_e;
				placed = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < RS_DEPTH; i++) begin
				ent[i].valid <= 1'b0;
			end
		end else begin
			ent <= nxt;
		end
	end

	// Unit must go busy right after it is started
	assert property (@(posedge clk) disable iff (reset)
		div_x.start |-> !div_x.busy ##1 div_x.busy);
	assert property (@(posedge clk) disable iff (reset)
		sqrt_x.start |-> !sqrt_x.busy ##1 sqrt_x.busy);

	// An accepted issue always lands in a free slot
	assert property (@(posedge clk) disable iff (reset)
		accept |=> $countones(vld) == $past($countones(vld)) + 1 - $past(dispatch));
endmodule

//--- source/fpu_ifs.sv
`timescale 1ns/1ps

interface issue_if;
	import fpu_pkg::*;

	logic valid;
	logic ready;
	fp_op_t op;
	logic [TAG_W-1:0] tag;
	logic opd0_ready;
	logic [TAG_W-1:0] opd0_tag;
	fp_word_t opd0_data;
	logic opd1_ready;
	logic [TAG_W-1:0] opd1_tag;
	fp_word_t opd1_data;

	modport issuer (
		output valid, op, tag, opd0_ready, opd0_tag, opd0_data,
		output opd1_ready, opd1_tag, opd1_data,
		input ready
	);
	modport station (
		input valid, op, tag, opd0_ready, opd0_tag, opd0_data,
		input opd1_ready, opd1_tag, opd1_data,
		output ready
	);
endinterface

interface exec_if;
	import fpu_pkg::*;

	logic start;
	logic busy;
	fp_word_t a;
	fp_word_t b;
	logic [TAG_W-1:0] tag;
	logic done;
	fp_word_t result;
	logic [TAG_W-1:0] rtag;
	logic ack;

	modport station (output start, a, b, tag, input busy);
	modport unit (input start, a, b, tag, ack, output busy, done, result, rtag);
	modport arbiter (input done, result, rtag, output ack);
endinterface

//--- source/fpu_pkg.sv
package fpu_pkg;

	localparam int TAG_W = 5;
	localparam int RS_DEPTH = 2;

	localparam int EXP_BIAS = 127;
	localparam int DIV_CYCLES = 26;  // Quotient bits incl. integer bit
	localparam int SQRT_CYCLES = 25;  // Root bits incl. guard

	typedef logic [31:0] fp_word_t;

	localparam fp_word_t QNAN = 32'h7fc00000;

	typedef enum logic {
		FDIV,
		FSQRT
	} fp_op_t;

	// Shared by both iterative units
	typedef enum logic [1:0] {
		IDLE,
		ITER,
		ROUND,
		HOLD
	} fu_state_t;

endpackage
